// File: logic/isa_pkg.sv
package isa_pkg;

    // Architectural widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  imem_addr_t;
    typedef logic [7:0]  dmem_addr_t;
    typedef logic [2:0]  alu_op_t;

    // Instruction fields
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [15:0] imm_t;

    // Primary opcodes
    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    // R-type function codes
    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

    // ALU operations
    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;

    // Storage sizes
    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;
    localparam int NUM_REGS   = 32;

endpackage

// File: logic/pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    // Control bits produced in decode and carried down the pipe
    typedef struct packed {
        logic    reg_write;
        logic    mem_to_reg;
        logic    mem_write;
        logic    branch;
        logic    alu_src;
        alu_op_t alu_op;
    } ctrl_t;

    // IF/ID
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    // ID/EX
    typedef struct packed {
        logic      valid;
        word_t     pc;
        ctrl_t     ctrl;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm;
        reg_addr_t dest;
    } id_ex_t;

    // EX/MEM
    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t dest;
    } ex_mem_t;

    // MEM/WB feeds the register-file write port in decode
    typedef struct packed {
        logic      valid;
        logic      reg_write;
        logic      mem_to_reg;
        word_t     alu_result;
        word_t     load_data;
        reg_addr_t dest;
    } mem_wb_t;

endpackage

// File: logic/register_file.sv
`timescale 1ns/1ps

module register_file
    import isa_pkg::*;
(
    input  logic      i_clk,
    input  reg_addr_t i_rs,
    input  reg_addr_t i_rt,
    output word_t     o_rs_data,
    output word_t     o_rt_data,
    input  logic      i_we,
    input  reg_addr_t i_wr_reg,
    input  word_t     i_wr_data
);

    word_t regs [NUM_REGS];

    // Same-cycle write is passed straight to the reader
    function automatic word_t read_port(input reg_addr_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (i_we && (i_wr_reg == addr)) begin
            value = i_wr_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    assign o_rs_data = read_port(i_rs);
    assign o_rt_data = read_port(i_rt);

    always_ff @(posedge i_clk) begin
        if (i_we && (i_wr_reg != '0)) begin
            regs[i_wr_reg] <= i_wr_data;
        end
    end

endmodule

// File: logic/seg_execute.sv
`timescale 1ns/1ps

module seg_execute
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst_n,
    input  id_ex_t  i_id_ex,
    output ex_mem_t o_ex_mem,
    output logic    o_squash,
    output word_t   o_target
);

    word_t   op_a;
    word_t   op_b;
    word_t   alu_result;
    logic    lt_signed;
    ex_mem_t ex_mem_next;

    assign op_a      = i_id_ex.rs_data;
    assign op_b      = i_id_ex.ctrl.alu_src ? i_id_ex.imm : i_id_ex.rt_data;
    assign lt_signed = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            ALU_ADD: alu_result = op_a + op_b;
            ALU_SUB: alu_result = op_a - op_b;
            ALU_AND: alu_result = op_a & op_b;
            ALU_OR:  alu_result = op_a | op_b;
            ALU_SLT: alu_result = {{31{1'b0}}, lt_signed};
            default: alu_result = '0;
        endcase
    end

    // Taken beq redirects fetch and kills the two younger entries
    assign o_squash = i_id_ex.valid && i_id_ex.ctrl.branch
                   && (i_id_ex.rs_data == i_id_ex.rt_data);
    assign o_target = i_id_ex.pc + 32'd4 + {i_id_ex.imm[29:0], 2'b00};

    // beq has nothing left to do past this stage
    assign ex_mem_next.valid      = i_id_ex.valid && !i_id_ex.ctrl.branch;
    assign ex_mem_next.ctrl       = i_id_ex.ctrl;
    assign ex_mem_next.alu_result = alu_result;
    assign ex_mem_next.store_data = i_id_ex.rt_data;
    assign ex_mem_next.dest       = i_id_ex.dest;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_ex_mem.valid <= 1'b0;
        end else begin
            o_ex_mem <= ex_mem_next;
        end
    end

endmodule

// File: logic/seg_instruction_decode.sv
`timescale 1ns/1ps

module seg_instruction_decode
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  if_id_t    i_if_id,
    input  logic      i_squash,
    input  mem_wb_t   i_mem_wb,
    output id_ex_t    o_id_ex,
    output logic      o_wb_valid,
    output reg_addr_t o_wb_reg,
    output word_t     o_wb_data
);

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    imm_t      imm;
    ctrl_t     ctrl;
    logic      known;
    word_t     rs_data;
    word_t     rt_data;
    logic      wb_we;
    word_t     wb_data;
    id_ex_t    id_ex_next;

    assign opcode = i_if_id.instr[31:26];
    assign rs     = i_if_id.instr[25:21];
    assign rt     = i_if_id.instr[20:16];
    assign rd     = i_if_id.instr[15:11];
    assign imm    = i_if_id.instr[15:0];
    assign funct  = i_if_id.instr[5:0];

    always_comb begin
        ctrl  = '0;
        known = 1'b1;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADD:  ctrl.alu_op = ALU_ADD;
                    FN_SUB:  ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: known = 1'b0;
                endcase
            end
            OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_ADD;
            end
            OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = ALU_ADD;
            end
            OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = ALU_ADD;
            end
            OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;
            end
            default: known = 1'b0;
        endcase
    end

    // Write-back select
    assign wb_data    = i_mem_wb.mem_to_reg ? i_mem_wb.load_data : i_mem_wb.alu_result;
    assign wb_we      = i_mem_wb.valid && i_mem_wb.reg_write && (i_mem_wb.dest != '0);
    assign o_wb_valid = wb_we;
    assign o_wb_reg   = i_mem_wb.dest;
    assign o_wb_data  = wb_data;

    register_file u_register_file (
        .i_clk     (i_clk),
        .i_rs      (rs),
        .i_rt      (rt),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data),
        .i_we      (wb_we),
        .i_wr_reg  (i_mem_wb.dest),
        .i_wr_data (wb_data)
    );

    assign id_ex_next.valid   = i_if_id.valid && known && !i_squash;
    assign id_ex_next.pc      = i_if_id.pc;
    assign id_ex_next.ctrl    = ctrl;
    assign id_ex_next.rs_data = rs_data;
    assign id_ex_next.rt_data = rt_data;
    assign id_ex_next.imm     = {{16{imm[15]}}, imm};
    assign id_ex_next.dest    = (opcode == OP_RTYPE) ? rd : rt;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_id_ex.valid <= 1'b0;
        end else begin
            o_id_ex <= id_ex_next;
        end
    end

endmodule

// File: logic/seg_instruction_fetch.sv
`timescale 1ns/1ps

module seg_instruction_fetch
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_run,
    input  logic       i_imem_we,
    input  imem_addr_t i_imem_addr,
    input  word_t      i_imem_wdata,
    input  logic       i_squash,
    input  word_t      i_target,
    output if_id_t     o_if_id
);

    word_t      imem [IMEM_DEPTH];
    word_t      pc;
    word_t      pc_next;
    imem_addr_t fetch_addr;
    if_id_t     if_id_next;

    // Loading is only allowed while the core is stopped
    always_ff @(posedge i_clk) begin
        if (i_imem_we && !i_run) begin
            imem[i_imem_addr] <= i_imem_wdata;
        end
    end

    assign fetch_addr = pc[9:2];

    always_comb begin
        if (!i_run) begin
            pc_next = pc;
        end else if (i_squash) begin
            pc_next = i_target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    // Word at the old PC is squashed along with the redirect
    assign if_id_next.valid = i_run && !i_squash;
    assign if_id_next.pc    = pc;
    assign if_id_next.instr = imem[fetch_addr];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pc            <= '0;
            o_if_id.valid <= 1'b0;
        end else begin
            pc      <= pc_next;
            o_if_id <= if_id_next;
        end
    end

endmodule

// File: logic/seg_memory_access.sv
`timescale 1ns/1ps

module seg_memory_access
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  ex_mem_t    i_ex_mem,
    output mem_wb_t    o_mem_wb,
    output logic       o_st_valid,
    output dmem_addr_t o_st_addr,
    output word_t      o_st_data
);

    word_t      dmem [DMEM_DEPTH];
    dmem_addr_t addr;
    logic       st_en;
    mem_wb_t    mem_wb_next;

    // Word index from the byte address
    assign addr  = i_ex_mem.alu_result[9:2];
    assign st_en = i_ex_mem.valid && i_ex_mem.ctrl.mem_write;

    assign o_st_valid = st_en;
    assign o_st_addr  = addr;
    assign o_st_data  = i_ex_mem.store_data;

    always_ff @(posedge i_clk) begin
        if (st_en) begin
            dmem[addr] <= i_ex_mem.store_data;
        end
    end

    assign mem_wb_next.valid      = i_ex_mem.valid;
    assign mem_wb_next.reg_write  = i_ex_mem.ctrl.reg_write;
    assign mem_wb_next.mem_to_reg = i_ex_mem.ctrl.mem_to_reg;
    assign mem_wb_next.alu_result = i_ex_mem.alu_result;
    assign mem_wb_next.load_data  = dmem[addr];
    assign mem_wb_next.dest       = i_ex_mem.dest;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_mem_wb.valid <= 1'b0;
        end else begin
            o_mem_wb <= mem_wb_next;
        end
    end

endmodule

// File: logic/top_mips.sv
`timescale 1ns/1ps

module top_mips
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst_n,
    input  logic       i_run,
    input  logic       i_imem_we,
    input  imem_addr_t i_imem_addr,
    input  word_t      i_imem_wdata,
    output logic       o_wb_valid,
    output reg_addr_t  o_wb_reg,
    output word_t      o_wb_data,
    output logic       o_st_valid,
    output dmem_addr_t o_st_addr,
    output word_t      o_st_data
);

    if_id_t  if_id;
    id_ex_t  id_ex;
    ex_mem_t ex_mem;
    mem_wb_t mem_wb;
    logic    squash;
    word_t   target;

    seg_instruction_fetch u_seg_instruction_fetch (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_run        (i_run),
        .i_imem_we    (i_imem_we),
        .i_imem_addr  (i_imem_addr),
        .i_imem_wdata (i_imem_wdata),
        .i_squash     (squash),
        .i_target     (target),
        .o_if_id      (if_id)
    );

    // Register write-back happens inside decode
    seg_instruction_decode u_seg_instruction_decode (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_if_id    (if_id),
        .i_squash   (squash),
        .i_mem_wb   (mem_wb),
        .o_id_ex    (id_ex),
        .o_wb_valid (o_wb_valid),
        .o_wb_reg   (o_wb_reg),
        .o_wb_data  (o_wb_data)
    );

    seg_execute u_seg_execute (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_id_ex  (id_ex),
        .o_ex_mem (ex_mem),
        .o_squash (squash),
        .o_target (target)
    );

    seg_memory_access u_seg_memory_access (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_ex_mem   (ex_mem),
        .o_mem_wb   (mem_wb),
        .o_st_valid (o_st_valid),
        .o_st_addr  (o_st_addr),
        .o_st_data  (o_st_data)
    );

endmodule

// File: tb/mips_cases.txt
// Per case: program words, write-back events, store events, run cycles,
// then the program, then (reg data) pairs, then (addr data) pairs; a zero count ends the list
// R-type ALU, wrap and signed slt
0c 09 00 18
2001ffff 20020005 00000000 00000000 00221820 00222022
00222824 00223025 0022382a 0041402a 00414822 1000ffff
01 ffffffff  02 00000005  03 00000004  04 fffffffa  05 00000005
06 ffffffff  07 00000001  08 00000000  09 00000006
// addi sign extension and register 0
07 05 00 14
20000007 200a8000 200b7fff 00006020 214d0001 216effff 1000ffff
0a ffff8000  0b 00007fff  0c 00000000  0d ffff8001  0e 00007ffe
// sw then lw of the same words
09 04 02 16
20010123 20020040 00000000 00000000 ac410008 ac42fffc
8c430008 8c44fffc 1000ffff
01 00000123  02 00000040  03 00000123  04 00000040
12 00000123  0f 00000040
// beq not taken, then taken over three words
0e 06 00 1a
20010003 20020003 20030004 00000000 00000000 10230001 20040011
20050022 10220003 20060033 20070044 20090066 20080055 1000ffff
01 00000003  02 00000003  03 00000004  04 00000011  05 00000022
08 00000055
00

// File: tb/tb_top_mips.sv
`timescale 1ns/1ps

module tb_top_mips
    import isa_pkg::*;
();

    localparam int CASE_WORDS  = 512;
    localparam int RESET_LEN   = 5;
    localparam int IDLE_CYCLES = 4;

    logic       clk;
    logic       rst_n;
    logic       run;
    logic       imem_we;
    imem_addr_t imem_addr;
    word_t      imem_wdata;
    logic       wb_valid;
    reg_addr_t  wb_reg;
    word_t      wb_data;
    logic       st_valid;
    dmem_addr_t st_addr;
    word_t      st_data;

    word_t      case_mem [CASE_WORDS];
    reg_addr_t  got_wb_reg [$];
    word_t      got_wb_data [$];
    dmem_addr_t got_st_addr [$];
    word_t      got_st_data [$];
    logic       collect;
    int         value_errors;
    int         event_errors;
    longint     limit_ns;
    logic       limit_ready;

    top_mips u_top_mips (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_run        (run),
        .i_imem_we    (imem_we),
        .i_imem_addr  (imem_addr),
        .i_imem_wdata (imem_wdata),
        .o_wb_valid   (wb_valid),
        .o_wb_reg     (wb_reg),
        .o_wb_data    (wb_data),
        .o_st_valid   (st_valid),
        .o_st_addr    (st_addr),
        .o_st_data    (st_data)
    );

    always #50 clk = ~clk;

    // Events captured mid-cycle
    always @(negedge clk) begin
        if (collect && wb_valid) begin
            got_wb_reg.push_back(wb_reg);
            got_wb_data.push_back(wb_data);
        end
        if (collect && st_valid) begin
            got_st_addr.push_back(st_addr);
            got_st_data.push_back(st_data);
        end
    end

    function automatic bit case_present(input int ptr);
        return (ptr < CASE_WORDS) && !$isunknown(case_mem[ptr]) && (case_mem[ptr] != '0);
    endfunction

    function automatic longint watchdog_limit();
        int     ptr;
        longint cycles;
        ptr    = 0;
        cycles = 0;
        while (case_present(ptr)) begin
            cycles += RESET_LEN + 2 + case_mem[ptr] + IDLE_CYCLES + case_mem[ptr + 3];
            ptr += 4 + case_mem[ptr] + 2 * case_mem[ptr + 1] + 2 * case_mem[ptr + 2];
        end
        return cycles * 100 + 5000;
    endfunction

    task automatic check_wb(input int case_no, input int idx, input reg_addr_t exp_reg,
                            input word_t exp_data, input reg_addr_t got_reg,
                            input word_t got_data);
        if (got_reg !== exp_reg) begin
            $display("FAIL case %0d wb %0d o_wb_reg got %h expected %h",
                     case_no, idx, got_reg, exp_reg);
            value_errors++;
        end
        if (got_data !== exp_data) begin
            $display("FAIL case %0d wb %0d o_wb_data got %h expected %h",
                     case_no, idx, got_data, exp_data);
            value_errors++;
        end
    endtask

    task automatic check_st(input int case_no, input int idx, input dmem_addr_t exp_addr,
                            input word_t exp_data, input dmem_addr_t got_addr,
                            input word_t got_data);
        if (got_addr !== exp_addr) begin
            $display("FAIL case %0d st %0d o_st_addr got %h expected %h",
                     case_no, idx, got_addr, exp_addr);
            value_errors++;
        end
        if (got_data !== exp_data) begin
            $display("FAIL case %0d st %0d o_st_data got %h expected %h",
                     case_no, idx, got_data, exp_data);
            value_errors++;
        end
    endtask

    task automatic run_case(input int case_no, inout int ptr);
        int n_prog;
        int n_wb;
        int n_st;
        int p;
        n_prog = case_mem[ptr];
        n_wb   = case_mem[ptr + 1];
        n_st   = case_mem[ptr + 2];
        p      = ptr + 4;
        got_wb_reg.delete();
        got_wb_data.delete();
        got_st_addr.delete();
        got_st_data.delete();
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (RESET_LEN) @(posedge clk);
        #1 rst_n = 1'b1;
        collect = 1'b1;
        // Program load with the core stopped
        for (int i = 0; i < n_prog; i++) begin
            imem_we    = 1'b1;
            imem_addr  = imem_addr_t'(i);
            imem_wdata = case_mem[p + i];
            @(posedge clk);
            #1;
        end
        imem_we = 1'b0;
        p += n_prog;
        repeat (IDLE_CYCLES) @(posedge clk);
        #1 run = 1'b1;
        repeat (case_mem[ptr + 3]) @(posedge clk);
        #1 run = 1'b0;
        collect = 1'b0;
        if (got_wb_reg.size() != n_wb) begin
            $display("Case %0d expected %0d write-back events but saw %0d",
                     case_no, n_wb, got_wb_reg.size());
            event_errors++;
        end
        for (int i = 0; i < n_wb && i < got_wb_reg.size(); i++) begin
            check_wb(case_no, i, reg_addr_t'(case_mem[p + 2 * i]), case_mem[p + 2 * i + 1],
                     got_wb_reg[i], got_wb_data[i]);
        end
        p += 2 * n_wb;
        if (got_st_addr.size() != n_st) begin
            $display("Case %0d expected %0d store events but saw %0d",
                     case_no, n_st, got_st_addr.size());
            event_errors++;
        end
        for (int i = 0; i < n_st && i < got_st_addr.size(); i++) begin
            check_st(case_no, i, dmem_addr_t'(case_mem[p + 2 * i]), case_mem[p + 2 * i + 1],
                     got_st_addr[i], got_st_data[i]);
        end
        ptr = p + 2 * n_st;
    endtask

    initial begin
        int ptr;
        int case_no;
        clk          = 1'b0;
        rst_n        = 1'b0;
        run          = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        collect      = 1'b0;
        value_errors = 0;
        event_errors = 0;
        limit_ready  = 1'b0;
        $readmemh("tb/mips_cases.txt", case_mem);
        limit_ns    = watchdog_limit();
        limit_ready = 1'b1;
        ptr         = 0;
        case_no     = 0;
        while (case_present(ptr)) begin
            run_case(case_no, ptr);
            case_no++;
        end
        if (case_no == 0) begin
            $display("No cases could be read from the cases file");
            event_errors++;
        end
        $display("Cases %0d, value errors %0d, event errors %0d",
                 case_no, value_errors, event_errors);
        if (value_errors == 0 && event_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        wait (limit_ready);
        #(limit_ns);
        $display("Timeout after %0d ns, the cases did not finish", limit_ns);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: tb/top_mips_properties.sv
`timescale 1ns/1ps

module top_mips_properties
    import isa_pkg::*;
(
    input logic      i_clk,
    input logic      i_rst_n,
    input logic      i_wb_valid,
    input reg_addr_t i_wb_reg,
    input word_t     i_wb_data,
    input logic      i_st_valid,
    input logic      i_squash,
    input logic      i_if_id_valid,
    input logic      i_id_ex_valid
);

    // Write-back events skip register 0 and carry known data
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_wb_valid |-> (i_wb_reg != '0) && !$isunknown(i_wb_data))
        else $error("write-back event to register 0 or with unknown data");

    assert property (@(posedge i_clk)
        !i_rst_n |=> (!i_wb_valid && !i_st_valid))
        else $error("write-back or store event while in reset");

    // Squash comes from a valid ID/EX entry and empties IF/ID and ID/EX
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_squash |-> i_id_ex_valid ##1 (!i_id_ex_valid && !i_if_id_valid))
        else $error("squash with an invalid ID/EX entry or younger entries left valid");

endmodule

bind top_mips top_mips_properties u_top_mips_properties (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_wb_valid    (o_wb_valid),
    .i_wb_reg      (o_wb_reg),
    .i_wb_data     (o_wb_data),
    .i_st_valid    (o_st_valid),
    .i_squash      (squash),
    .i_if_id_valid (if_id.valid),
    .i_id_ex_valid (id_ex.valid)
);

// File: top_mips.f
logic/isa_pkg.sv
logic/pipe_pkg.sv
logic/register_file.sv
logic/seg_instruction_fetch.sv
logic/seg_instruction_decode.sv
logic/seg_execute.sv
logic/seg_memory_access.sv
logic/top_mips.sv
tb/top_mips_properties.sv
tb/tb_top_mips.sv
